//--- hdl/core4t_macros.svh
/* Global sizes for the barrel core
   Word width, thread and register counts, reset PC, NOP encoding */
`ifndef CORE4T_MACROS_SVH
`define CORE4T_MACROS_SVH

`define XLEN        32              // Data path width
`define NUM_THREADS 4               // Barrel depth, one thread per pipe stage
`define NUM_REGS    32              // Architectural registers per thread
`define RESET_PC    32'h0000_0000   // Common start address
`define NOP_INST    32'h0000_0013   // ADDI x0,x0,0

`endif

//--- hdl/core4tPkg.sv
/* Shared vector types of the barrel core
   RV32I base opcodes and ALU operation codes */
`include "core4t_macros.svh"

package core4tPkg;

    typedef logic [`XLEN-1:0]        wordT;     // Data or address word
    typedef logic [`XLEN-1:0]        pcT;
    typedef logic [31:0]             instT;
    typedef logic [4:0]              regIdxT;
    typedef logic [`NUM_THREADS-1:0] threadT;   // One-hot thread token
    typedef logic [3:0]              byteEnT;
    typedef logic [2:0]              funct3T;
    typedef logic [3:0]              aluOpT;    // {funct7[5], funct3}

    ////////////////////
    // Base opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_OPIMM  = 7'b0010011;
    localparam logic [6:0] OP_OP     = 7'b0110011;

    ////////////////////
    // ALU operations, funct7[5] on top of funct3
    localparam aluOpT ALU_ADD  = 4'b0000;
    localparam aluOpT ALU_SUB  = 4'b1000;
    localparam aluOpT ALU_SLL  = 4'b0001;
    localparam aluOpT ALU_SLT  = 4'b0010;
    localparam aluOpT ALU_SLTU = 4'b0011;
    localparam aluOpT ALU_XOR  = 4'b0100;
    localparam aluOpT ALU_SRL  = 4'b0101;
    localparam aluOpT ALU_SRA  = 4'b1101;
    localparam aluOpT ALU_OR   = 4'b0110;
    localparam aluOpT ALU_AND  = 4'b0111;

endpackage

//--- hdl/threadFetch.sv
/* Thread token rotor and per-thread PCs
   Fetch PC mux and the Q101H PC flop */
`timescale 1ns/1ps
`include "core4t_macros.svh"

module threadFetch import core4tPkg::*; (
    input  logic   QClk,
    input  logic   reset,
    input  pcT     nextPcQ102H,     // From execute, for the Q102H thread
    output pcT     PcQ100H,         // To instruction memory
    output pcT     PcQ101H,
    output threadT ThreadQ101H,
    output threadT ThreadQ102H,
    output threadT ThreadQ103H,
    output threadT ThreadQ104H
);

    threadT ThreadQ100H;
    pcT     threadPc [`NUM_THREADS];
    logic   validQ101H;             // Real fetch has reached decode
    logic   validQ102H;             // Real fetch has reached execute

    ////////////////////
    // Token rotor
    always_ff @(posedge QClk) begin
        if (reset) begin
            ThreadQ100H <= threadT'(1);     // Thread 0 first
        end else begin
            ThreadQ100H <= {ThreadQ100H[`NUM_THREADS-2:0], ThreadQ100H[`NUM_THREADS-1]};
        end
    end

    // Each later stage sits one thread behind
    assign ThreadQ101H = {ThreadQ100H[0], ThreadQ100H[`NUM_THREADS-1:1]};
    assign ThreadQ102H = {ThreadQ101H[0], ThreadQ101H[`NUM_THREADS-1:1]};
    assign ThreadQ103H = {ThreadQ102H[0], ThreadQ102H[`NUM_THREADS-1:1]};
    assign ThreadQ104H = ThreadQ100H;       // Full turn of the barrel

    // Bubbles left over from reset must not advance a PC
    always_ff @(posedge QClk) begin
        if (reset) begin
            validQ101H <= 1'b0;
            validQ102H <= 1'b0;
        end else begin
            validQ101H <= 1'b1;
            validQ102H <= validQ101H;
        end
    end

    ////////////////////
    // PC registers
    always_ff @(posedge QClk) begin
        for (int i = 0; i < `NUM_THREADS; i++) begin
            if (reset) begin
                threadPc[i] <= `RESET_PC;
            end else if (validQ102H && ThreadQ102H[i]) begin
                threadPc[i] <= nextPcQ102H;     // Ready two cycles before next fetch
            end
        end
    end

    always_comb begin
        PcQ100H = threadPc[0];
        for (int i = 1; i < `NUM_THREADS; i++) begin
            if (ThreadQ100H[i]) begin
                PcQ100H = threadPc[i];
            end
        end
    end

    always_ff @(posedge QClk) begin
        PcQ101H <= PcQ100H;     // Instruction word itself is flopped in memory
    end

    // Rotor keeps exactly one thread in each stage
    assert property (@(posedge QClk) disable iff (reset) $onehot(ThreadQ100H));

endmodule

//--- hdl/instDecode.sv
/* Opcode decoder and source pointer extraction
   Q101H to Q102H instruction, operand and control flops */
`timescale 1ns/1ps

module instDecode import core4tPkg::*; (
    input  logic   QClk,
    input  logic   reset,
    input  instT   InstFetchQ101H,
    input  pcT     PcQ101H,
    input  wordT   RdData1Q101H,
    input  wordT   RdData2Q101H,
    output regIdxT RdPtr1Q101H,
    output regIdxT RdPtr2Q101H,
    output instT   InstQ102H,
    output pcT     PcQ102H,
    output wordT   RdData1Q102H,
    output wordT   RdData2Q102H,
    output logic   JalQ102H,
    output logic   JalrQ102H,
    output logic   BranchQ102H,
    output logic   ITypeImmQ102H,
    output logic   StoreQ102H,
    output logic   LuiQ102H,
    output logic   AuiPcQ102H,
    output logic   MemToRegQ102H,
    output logic   PcToRegQ102H,
    output logic   MemRdQ102H,
    output logic   MemWrQ102H,
    output logic   RegWrQ102H
);

    logic [6:0] opcodeQ101H;
    logic [11:0] ctrlQ101H;     // Flags in output order

    assign opcodeQ101H = InstFetchQ101H[6:0];
    assign RdPtr1Q101H = InstFetchQ101H[19:15];     // rs1
    assign RdPtr2Q101H = InstFetchQ101H[24:20];     // rs2

    ////////////////////
    // Control decode
    assign ctrlQ101H = {
        opcodeQ101H == OP_JAL,
        opcodeQ101H == OP_JALR,
        opcodeQ101H == OP_BRANCH,
        opcodeQ101H inside {OP_OPIMM, OP_LOAD, OP_JALR},   // I-immediate into ALU
        opcodeQ101H == OP_STORE,
        opcodeQ101H == OP_LUI,
        opcodeQ101H == OP_AUIPC,
        opcodeQ101H == OP_LOAD,                             // Load data to rd
        opcodeQ101H inside {OP_JAL, OP_JALR},               // Link to rd
        opcodeQ101H == OP_LOAD,
        opcodeQ101H == OP_STORE,
        opcodeQ101H inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_OPIMM, OP_OP}
    };

    always_ff @(posedge QClk) begin
        if (reset) begin
            {JalQ102H, JalrQ102H, BranchQ102H, ITypeImmQ102H, StoreQ102H, LuiQ102H,
             AuiPcQ102H, MemToRegQ102H, PcToRegQ102H, MemRdQ102H, MemWrQ102H,
             RegWrQ102H} <= '0;
        end else begin
            {JalQ102H, JalrQ102H, BranchQ102H, ITypeImmQ102H, StoreQ102H, LuiQ102H,
             AuiPcQ102H, MemToRegQ102H, PcToRegQ102H, MemRdQ102H, MemWrQ102H,
             RegWrQ102H} <= ctrlQ101H;
        end
    end

    // Payload into execute
    always_ff @(posedge QClk) begin
        InstQ102H    <= InstFetchQ101H;
        PcQ102H      <= PcQ101H;
        RdData1Q102H <= RdData1Q101H;
        RdData2Q102H <= RdData2Q101H;
    end

endmodule

//--- hdl/threadRegFile.sv
/* Four register banks, one per thread
   Read at Q101H, written at Q104H, x0 reads zero */
`timescale 1ns/1ps
`include "core4t_macros.svh"

module threadRegFile import core4tPkg::*; (
    input  logic   QClk,
    input  threadT ThreadQ101H,     // Bank to read
    input  threadT ThreadQ104H,     // Bank to write
    input  regIdxT RdPtr1Q101H,
    input  regIdxT RdPtr2Q101H,
    input  logic   WrEnQ104H,
    input  regIdxT WrPtrQ104H,
    input  wordT   WrDataQ104H,
    output wordT   RdData1Q101H,
    output wordT   RdData2Q101H
);

    localparam int ThreadIdxW = $clog2(`NUM_THREADS);

    wordT regBank [`NUM_THREADS][`NUM_REGS];
    logic [ThreadIdxW-1:0] rdBankQ101H;

    // One-hot token to bank index
    always_comb begin
        rdBankQ101H = '0;
        for (int i = 0; i < `NUM_THREADS; i++) begin
            if (ThreadQ101H[i]) begin
                rdBankQ101H = ThreadIdxW'(i);
            end
        end
    end

    ////////////////////
    // Read ports, x0 forced to zero
    assign RdData1Q101H = (RdPtr1Q101H == '0) ? '0 : regBank[rdBankQ101H][RdPtr1Q101H];
    assign RdData2Q101H = (RdPtr2Q101H == '0) ? '0 : regBank[rdBankQ101H][RdPtr2Q101H];

    // Write port
    always_ff @(posedge QClk) begin
        for (int t = 0; t < `NUM_THREADS; t++) begin
            if (WrEnQ104H && ThreadQ104H[t]) begin
                regBank[t][WrPtrQ104H] <= WrDataQ104H;  // Entry 0 stored but never read
            end
        end
    end

endmodule

//--- hdl/executeStage.sv
/* Q102H immediates, ALU control, ALU and branch compare
   Next-PC select and the Q102H to Q103H flops */
`timescale 1ns/1ps

module executeStage import core4tPkg::*; (
    input  logic   QClk,
    input  logic   reset,
    input  instT   InstQ102H,
    input  pcT     PcQ102H,
    input  wordT   RdData1Q102H,
    input  wordT   RdData2Q102H,
    input  logic   JalQ102H,
    input  logic   JalrQ102H,
    input  logic   BranchQ102H,
    input  logic   ITypeImmQ102H,
    input  logic   StoreQ102H,
    input  logic   LuiQ102H,
    input  logic   AuiPcQ102H,
    input  logic   MemToRegQ102H,
    input  logic   PcToRegQ102H,
    input  logic   MemRdQ102H,
    input  logic   MemWrQ102H,
    input  logic   RegWrQ102H,
    output pcT     NextPcQ102H,
    output wordT   AluOutQ103H,
    output pcT     PcPlus4Q103H,
    output wordT   StoreDataQ103H,
    output funct3T Funct3Q103H,
    output regIdxT WrPtrQ103H,
    output logic   MemRdQ103H,
    output logic   MemWrQ103H,
    output logic   MemToRegQ103H,
    output logic   PcToRegQ103H,
    output logic   RegWrQ103H,
    output pcT     PcQ103H
);

    logic [6:0] opcodeQ102H;
    funct3T     funct3Q102H;
    wordT       iImmQ102H;
    wordT       sImmQ102H;
    wordT       bImmQ102H;
    wordT       uImmQ102H;
    wordT       jImmQ102H;
    aluOpT      aluOpQ102H;
    wordT       aluIn1Q102H;
    wordT       aluIn2Q102H;
    wordT       aluOutQ102H;
    pcT         pcPlus4Q102H;
    logic       takenQ102H;         // Branch condition met

    assign opcodeQ102H = InstQ102H[6:0];
    assign funct3Q102H = InstQ102H[14:12];

    ////////////////////
    // Immediate generator
    assign iImmQ102H = {{20{InstQ102H[31]}}, InstQ102H[31:20]};
    assign sImmQ102H = {{20{InstQ102H[31]}}, InstQ102H[31:25], InstQ102H[11:7]};
    assign bImmQ102H = {{20{InstQ102H[31]}}, InstQ102H[7], InstQ102H[30:25],
                        InstQ102H[11:8], 1'b0};
    assign uImmQ102H = {InstQ102H[31:12], 12'b0};
    assign jImmQ102H = {{12{InstQ102H[31]}}, InstQ102H[19:12], InstQ102H[20],
                        InstQ102H[30:21], 1'b0};

    // ALU op, ADD for address, link and upper-immediate forms
    always_comb begin
        aluOpQ102H = ALU_ADD;
        if (opcodeQ102H == OP_OP) begin
            aluOpQ102H = {InstQ102H[30], funct3Q102H};
        end else if (opcodeQ102H == OP_OPIMM) begin
            // funct7 only qualifies the immediate shifts
            aluOpQ102H = {(funct3Q102H[1:0] == 2'b01) & InstQ102H[30], funct3Q102H};
        end
    end

    // Operand select, register pair by default
    always_comb begin
        aluIn1Q102H = RdData1Q102H;
        aluIn2Q102H = RdData2Q102H;
        if (LuiQ102H) begin
            aluIn1Q102H = '0;
            aluIn2Q102H = uImmQ102H;
        end else if (AuiPcQ102H) begin
            aluIn1Q102H = PcQ102H;
            aluIn2Q102H = uImmQ102H;
        end else if (ITypeImmQ102H) begin
            aluIn2Q102H = iImmQ102H;    // OP-IMM, loads, JALR
        end else if (StoreQ102H) begin
            aluIn2Q102H = sImmQ102H;
        end
    end

    ////////////////////
    // ALU
    always_comb begin
        case (aluOpQ102H)
            ALU_ADD:  aluOutQ102H = aluIn1Q102H + aluIn2Q102H;
            ALU_SUB:  aluOutQ102H = aluIn1Q102H - aluIn2Q102H;
            ALU_SLT:  aluOutQ102H = wordT'($signed(aluIn1Q102H) < $signed(aluIn2Q102H));
            ALU_SLTU: aluOutQ102H = wordT'(aluIn1Q102H < aluIn2Q102H);
            ALU_SLL:  aluOutQ102H = aluIn1Q102H << aluIn2Q102H[4:0];
            ALU_SRL:  aluOutQ102H = aluIn1Q102H >> aluIn2Q102H[4:0];
            ALU_SRA:  aluOutQ102H = $signed(aluIn1Q102H) >>> aluIn2Q102H[4:0];
            ALU_XOR:  aluOutQ102H = aluIn1Q102H ^ aluIn2Q102H;
            ALU_OR:   aluOutQ102H = aluIn1Q102H | aluIn2Q102H;
            ALU_AND:  aluOutQ102H = aluIn1Q102H & aluIn2Q102H;
            default:  aluOutQ102H = '0;     // Unused codes
        endcase
    end

    // Branch compare straight on rs1 and rs2
    always_comb begin
        takenQ102H = 1'b0;
        if (BranchQ102H) begin
            case (funct3Q102H)
                3'b000:  takenQ102H = RdData1Q102H == RdData2Q102H;                      // BEQ
                3'b001:  takenQ102H = RdData1Q102H != RdData2Q102H;                      // BNE
                3'b100:  takenQ102H = $signed(RdData1Q102H) < $signed(RdData2Q102H);     // BLT
                3'b101:  takenQ102H = $signed(RdData1Q102H) >= $signed(RdData2Q102H);    // BGE
                3'b110:  takenQ102H = RdData1Q102H < RdData2Q102H;                       // BLTU
                3'b111:  takenQ102H = RdData1Q102H >= RdData2Q102H;                      // BGEU
                default: takenQ102H = 1'b0;
            endcase
        end
    end

    ////////////////////
    // Next PC
    assign pcPlus4Q102H = PcQ102H + pcT'(4);

    always_comb begin
        if (JalrQ102H) begin
            NextPcQ102H = aluOutQ102H;      // rs1 + I-imm, bit 0 kept
        end else if (JalQ102H) begin
            NextPcQ102H = PcQ102H + jImmQ102H;
        end else if (takenQ102H) begin
            NextPcQ102H = PcQ102H + bImmQ102H;
        end else begin
            NextPcQ102H = pcPlus4Q102H;
        end
    end

    // Q103H control flops
    always_ff @(posedge QClk) begin
        if (reset) begin
            {MemRdQ103H, MemWrQ103H, MemToRegQ103H, PcToRegQ103H, RegWrQ103H} <= '0;
        end else begin
            {MemRdQ103H, MemWrQ103H, MemToRegQ103H, PcToRegQ103H, RegWrQ103H} <=
                {MemRdQ102H, MemWrQ102H, MemToRegQ102H, PcToRegQ102H, RegWrQ102H};
        end
    end

    // Q103H payload
    always_ff @(posedge QClk) begin
        AluOutQ103H    <= aluOutQ102H;
        PcPlus4Q103H   <= pcPlus4Q102H;
        StoreDataQ103H <= RdData2Q102H;     // rs2 for stores
        Funct3Q103H    <= funct3Q102H;
        WrPtrQ103H     <= InstQ102H[11:7];  // rd
        PcQ103H        <= NextPcQ102H;
    end

endmodule

//--- hdl/memWriteback.sv
/* Q103H byte enables toward data memory
   Q104H flops and the register write data select */
`timescale 1ns/1ps

module memWriteback import core4tPkg::*; (
    input  logic   QClk,
    input  logic   reset,
    input  wordT   AluOutQ103H,
    input  pcT     PcPlus4Q103H,
    input  funct3T Funct3Q103H,
    input  regIdxT WrPtrQ103H,
    input  logic   MemRdQ103H,
    input  logic   MemWrQ103H,
    input  logic   MemToRegQ103H,
    input  logic   PcToRegQ103H,
    input  logic   RegWrQ103H,
    input  wordT   MemRdDataQ104H,  // One cycle after the read strobe
    output byteEnT MemByteEnQ103H,
    output logic   WrEnQ104H,
    output regIdxT WrPtrQ104H,
    output wordT   WrDataQ104H
);

    wordT aluOutQ104H;
    pcT   pcPlus4Q104H;
    logic memToRegQ104H;
    logic pcToRegQ104H;

    // Access size from funct3
    always_comb begin
        case (Funct3Q103H[1:0])
            2'b00:   MemByteEnQ103H = 4'b0001;  // Byte
            2'b01:   MemByteEnQ103H = 4'b0011;  // Half
            2'b10:   MemByteEnQ103H = 4'b1111;  // Word
            default: MemByteEnQ103H = 4'b0000;  // Reserved size
        endcase
    end

    always_ff @(posedge QClk) begin
        if (reset) begin
            {WrEnQ104H, memToRegQ104H, pcToRegQ104H} <= '0;
        end else begin
            {WrEnQ104H, memToRegQ104H, pcToRegQ104H} <=
                {RegWrQ103H, MemToRegQ103H, PcToRegQ103H};
        end
    end

    always_ff @(posedge QClk) begin
        aluOutQ104H  <= AluOutQ103H;
        pcPlus4Q104H <= PcPlus4Q103H;
        WrPtrQ104H   <= WrPtrQ103H;
    end

    // Load data, link address, else ALU result
    assign WrDataQ104H = memToRegQ104H ? MemRdDataQ104H :
                         pcToRegQ104H  ? pcPlus4Q104H   : aluOutQ104H;

    // Decode never raises both strobes for one instruction
    assert property (@(posedge QClk) disable iff (reset) !(MemRdQ103H && MemWrQ103H));
    // Reserved size code never reaches the data bus
    assert property (@(posedge QClk) disable iff (reset)
        (MemRdQ103H || MemWrQ103H) |-> (Funct3Q103H[1:0] != 2'b11));

endmodule

//--- hdl/core4t.sv
/* Top of the four-thread barrel RV32I core
   Stage wiring and the instruction and data memory ports */
`timescale 1ns/1ps

module core4t import core4tPkg::*; (
    input  logic   QClk,
    input  logic   reset,
    output pcT     PcQ100H,         // Instruction memory
    input  instT   InstFetchQ101H,
    output wordT   MemAdrsQ103H,    // Data memory
    output wordT   MemWrDataQ103H,
    output logic   MemRdQ103H,
    output logic   MemWrQ103H,
    output byteEnT MemByteEnQ103H,
    output threadT ThreadQ103H,
    output pcT     PcQ103H,         // Next PC of the Q103H thread
    input  wordT   MemRdDataQ104H
);

    // Fetch and decode
    pcT     PcQ101H;
    threadT ThreadQ101H;
    threadT ThreadQ104H;
    regIdxT RdPtr1Q101H;
    regIdxT RdPtr2Q101H;
    wordT   RdData1Q101H;
    wordT   RdData2Q101H;
    // Execute
    instT   InstQ102H;
    pcT     PcQ102H;
    pcT     NextPcQ102H;
    wordT   RdData1Q102H;
    wordT   RdData2Q102H;
    logic   JalQ102H;
    logic   JalrQ102H;
    logic   BranchQ102H;
    logic   ITypeImmQ102H;
    logic   StoreQ102H;
    logic   LuiQ102H;
    logic   AuiPcQ102H;
    logic   MemToRegQ102H;
    logic   PcToRegQ102H;
    logic   MemRdQ102H;
    logic   MemWrQ102H;
    logic   RegWrQ102H;
    // Memory and writeback
    wordT   AluOutQ103H;
    pcT     PcPlus4Q103H;
    wordT   StoreDataQ103H;
    funct3T Funct3Q103H;
    regIdxT WrPtrQ103H;
    logic   MemToRegQ103H;
    logic   PcToRegQ103H;
    logic   RegWrQ103H;
    logic   WrEnQ104H;
    regIdxT WrPtrQ104H;
    wordT   WrDataQ104H;

    ////////////////////
    // Stages wired by matching names
    threadFetch   fetchStage  (.nextPcQ102H(NextPcQ102H), .ThreadQ102H(), .*);
    instDecode    decodeStage (.*);
    threadRegFile regFile     (.*);
    executeStage  execStage   (.*);
    memWriteback  wbStage     (.*);

    assign MemAdrsQ103H   = AluOutQ103H;        // rs1 + offset
    assign MemWrDataQ103H = StoreDataQ103H;     // rs2

endmodule

//--- dv/tbClockGen.sv
/* Testbench clock, 20 ns period
   Reset held for the first two rising edges */
`timescale 1ns/1ps

module tbClockGen (
    output logic QClk,
    output logic reset
);

    initial begin
        QClk = 1'b0;
        forever #10 QClk = ~QClk;   // Half period
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge QClk);
        #1 reset = 1'b0;            // Released just after the second edge
    end

endmodule

//--- dv/core4tTb.sv
/* Barrel core testbench with LFSR instruction stream and memories
   Per-thread architectural model, compare tasks and report */
`timescale 1ns/1ps
`include "core4t_macros.svh"

module core4tTb import core4tPkg::*; ();

    localparam int KindOp = 0, KindOpImm = 1, KindLui = 2, KindAuiPc = 3, KindJal = 4;
    localparam int KindJalr = 5, KindBranch = 6, KindLoad = 7, KindStore = 8;
    localparam int InitFetches  = 124;     // One LUI per thread and register
    localparam int TotalFetches = 2000;
    localparam int ResetTimeout = 8;

    typedef struct packed {
        threadT tok;
        pcT     nextPc;
        logic   memRd;
        logic   memWr;
        wordT   adrs;
        wordT   wrData;
        byteEnT byteEn;
        int     test;
    } expT;

    logic QClk, reset;
    pcT PcQ100H, PcQ103H;
    instT InstFetchQ101H;
    wordT MemAdrsQ103H, MemWrDataQ103H, MemRdDataQ104H;
    logic MemRdQ103H, MemWrQ103H;
    byteEnT MemByteEnQ103H;
    threadT ThreadQ103H;

    logic [15:0] lfsrState;
    wordT modelReg [`NUM_THREADS][32];
    pcT modelPc [`NUM_THREADS];
    expT expQ [$];
    instT pendInst;                     // Instruction memory output register
    wordT pendRdData;                   // Data memory output register
    int checkCnt, errCnt, checkTest, lastTest;
    int testChk [7];
    int testErr [7];

    tbClockGen clockGen (.QClk(QClk), .reset(reset));

    core4t core4t_inst (.*);

    ////////////////////
    // Random source
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        logic fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], fb};  // One step per bit
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic int testOf(input int f);
        if (f < 4) return 1;                // First fetch of each thread
        if (f < 400) return 2;
        if (f < 800) return 3;
        if (f < 1200) return 4;
        if (f < 1600) return 5;
        return 6;
    endfunction

    function automatic string testName(input int t);
        case (t)
            1: return "reset";
            2: return "LUI and AUIPC";
            3: return "ALU operations";
            4: return "loads and byte enables";
            5: return "control flow";
            default: return "thread isolation";
        endcase
    endfunction

    // Instruction mix per test with one kind per nibble
    function automatic int pickKind(input int test, input logic [2:0] slot);
        logic [31:0] mix;
        int idx;
        case (test)
            2: mix = 32'h8188_3232;
            3: mix = 32'h8811_1000;
            4: mix = 32'h0188_8777;
            5: mix = 32'h8810_5466;
            6: mix = 32'h6888_2710;
            default: mix = 32'h2222_2222;
        endcase
        idx = 4 * int'(slot);
        return int'(mix[idx +: 4]);
    endfunction

    ////////////////////
    // ISA reference rules
    function automatic wordT sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic wordT aluModel(input logic alt, input funct3T f3, input wordT a,
                                      input wordT b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'd0: if (alt) return a - b; else return a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: if (alt) return sa >>> b[4:0]; else return a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(input funct3T f3, input wordT a, input wordT b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;                 // Unsigned pair
            default: return a >= b;
        endcase
    endfunction

    function automatic byteEnT byteEnFor(input funct3T f3);
        case (f3[1:0])
            2'b00: return 4'b0001;
            2'b01: return 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    ////////////////////
    // Compare tasks
    task automatic countCheck(input logic bad);
        checkCnt++;
        testChk[checkTest]++;
        if (bad) begin
            errCnt++;
            testErr[checkTest]++;
        end
    endtask

    task automatic checkPc(input string name, input pcT got, input pcT exp);
        countCheck(got !== exp);
        if (got !== exp) $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
    endtask

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        countCheck(got !== exp);
        if (got !== exp) $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
    endtask

    task automatic checkByteEn(input string name, input byteEnT got, input byteEnT exp);
        countCheck(got !== exp);
        if (got !== exp) $display("Error: %s got 0x%01h expected 0x%01h", name, got, exp);
    endtask

    task automatic checkThread(input string name, input threadT got, input threadT exp);
        countCheck(got !== exp);
        if (got !== exp) $display("Error: %s got 0x%01h expected 0x%01h", name, got, exp);
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        countCheck(got !== exp);
        if (got !== exp) $display("Error: %s got 0x%01h expected 0x%01h", name, got, exp);
    endtask

    task automatic checkStrobesLow();
        checkTest = 1;
        checkFlag("MemRdQ103H", MemRdQ103H, 1'b0);
        checkFlag("MemWrQ103H", MemWrQ103H, 1'b0);
    endtask

    task automatic reportTest(input int t);
        $display("Test %0d %s: %0d checks, %0d errors", t, testName(t), testChk[t], testErr[t]);
    endtask

    // Q103H holds the fetch from three cycles back
    task automatic checkQ103();
        expT e;
        if (expQ.size() == 0) begin
            countCheck(1'b1);
            $display("Expected-result queue ran empty at Q103H");
            return;
        end
        e = expQ.pop_front();
        if (e.test != lastTest) begin
            reportTest(lastTest);               // Previous test fully checked
            lastTest = e.test;
        end
        checkTest = e.test;
        checkThread("ThreadQ103H", ThreadQ103H, e.tok);
        checkPc("PcQ103H", PcQ103H, e.nextPc);
        checkFlag("MemRdQ103H", MemRdQ103H, e.memRd);
        checkFlag("MemWrQ103H", MemWrQ103H, e.memWr);
        if (e.memRd || e.memWr) begin
            checkWord("MemAdrsQ103H", MemAdrsQ103H, e.adrs);
            checkByteEn("MemByteEnQ103H", MemByteEnQ103H, e.byteEn);
        end
        if (e.memWr) checkWord("MemWrDataQ103H", MemWrDataQ103H, e.wrData);
    endtask

    ////////////////////
    // Fetch, generate and execute in the model
    task automatic fetchOne(input int f);
        int thr;
        int kind;
        regIdxT rd;
        regIdxT rs1;
        regIdxT rs2;
        funct3T f3;
        logic alt;
        logic [11:0] imm;
        logic [19:0] upper;
        wordT rv1;
        wordT rv2;
        wordT res;
        logic wr;
        instT inst;
        expT e;
        thr = f % `NUM_THREADS;
        checkTest = testOf(f);
        checkPc("PcQ100H", PcQ100H, modelPc[thr]);
        rd = 5'(randBits(5));
        rs1 = 5'(randBits(5));
        rs2 = 5'(randBits(5));
        f3 = 3'(randBits(3));
        imm = 12'(randBits(12));
        upper = 20'(randBits(20));
        rv1 = modelReg[thr][rs1];
        rv2 = modelReg[thr][rs2];
        kind = (f < InitFetches) ? KindLui : pickKind(checkTest, 3'(randBits(3)));
        if (f < InitFetches) rd = 5'(f / `NUM_THREADS + 1);    // Fill every register first
        e = '0;
        e.tok = threadT'(1 << thr);
        e.nextPc = modelPc[thr] + 32'd4;
        e.test = checkTest;
        wr = 1'b1;
        res = '0;
        case (kind)
            KindOp: begin
                alt = (f3 == 3'd0 || f3 == 3'd5) ? randBits(1) : 1'b0;   // SUB or SRA
                inst = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP_OP};
                res = aluModel(alt, f3, rv1, rv2);
            end
            KindOpImm: begin
                alt = 1'b0;
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    alt = (f3 == 3'd5) && imm[10];
                    imm = {1'b0, alt, 5'b0, imm[4:0]};   // Shift amount only
                end
                inst = {imm, rs1, f3, rd, OP_OPIMM};
                res = aluModel(alt, f3, rv1, sext12(imm));
            end
            KindLui: begin
                inst = {upper, rd, OP_LUI};
                res = {upper, 12'b0};
            end
            KindAuiPc: begin
                inst = {upper, rd, OP_AUIPC};
                res = modelPc[thr] + {upper, 12'b0};
            end
            KindJal: begin
                inst = {upper[19], upper[9:0], upper[10], upper[18:11], rd, OP_JAL};
                res = modelPc[thr] + 32'd4;
                e.nextPc = modelPc[thr] + {{11{upper[19]}}, upper, 1'b0};
            end
            KindJalr: begin
                inst = {imm, rs1, 3'b000, rd, OP_JALR};
                res = modelPc[thr] + 32'd4;
                e.nextPc = rv1 + sext12(imm);   // Bit 0 kept
            end
            KindBranch: begin
                if (f3 == 3'd2 || f3 == 3'd3) f3[1] = 1'b0;   // No such branches
                inst = {imm[11], imm[9:4], rs2, rs1, f3, imm[3:0], imm[10], OP_BRANCH};
                wr = 1'b0;
                if (branchTaken(f3, rv1, rv2)) e.nextPc = modelPc[thr] + {sext12(imm), 1'b0};
            end
            KindLoad: begin
                f3 = (f3[1:0] == 2'b11) ? 3'd2 : {1'b0, f3[1:0]};
                inst = {imm, rs1, f3, rd, OP_LOAD};
                e.memRd = 1'b1;
                e.adrs = rv1 + sext12(imm);
                e.byteEn = byteEnFor(f3);
                res = ~e.adrs;                  // Data memory returns inverted address
            end
            KindStore: begin
                f3 = (f3[1:0] == 2'b11) ? 3'd2 : {1'b0, f3[1:0]};
                inst = {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
                wr = 1'b0;
                e.memWr = 1'b1;
                e.adrs = rv1 + sext12(imm);
                e.wrData = rv2;
                e.byteEn = byteEnFor(f3);
            end
        endcase
        if (wr && rd != 5'd0) modelReg[thr][rd] = res;   // x0 stays zero
        modelPc[thr] = e.nextPc;
        expQ.push_back(e);
        pendInst = inst;
    endtask

    ////////////////////
    // Cycle loop
    initial begin
        int f;
        int resetCycles;
        logic timedOut;
        InstFetchQ101H = `NOP_INST;
        MemRdDataQ104H = '0;
        pendInst = `NOP_INST;
        pendRdData = '0;
        lfsrState = 16'd15800;
        checkCnt = 0;
        errCnt = 0;
        checkTest = 1;
        lastTest = 1;
        timedOut = 1'b0;
        for (int t = 0; t < 7; t++) begin
            testChk[t] = 0;
            testErr[t] = 0;
        end
        for (int t = 0; t < `NUM_THREADS; t++) begin
            modelPc[t] = `RESET_PC;
            for (int r = 0; r < 32; r++) modelReg[t][r] = '0;
        end
        f = 0;
        resetCycles = 0;
        while (!timedOut && f < TotalFetches + 3) begin
            @(posedge QClk);
            #1;
            InstFetchQ101H = pendInst;          // Memory outputs update 1 ns after the edge
            MemRdDataQ104H = pendRdData;
            @(negedge QClk);
            if (reset) begin
                resetCycles++;
                checkStrobesLow();
                pendInst = `NOP_INST;
                pendRdData = '0;
                if (resetCycles > ResetTimeout) begin
                    $display("Timeout: reset was never released");
                    timedOut = 1'b1;
                end
            end else begin
                pendRdData = MemRdQ103H ? ~MemAdrsQ103H : '0;
                if (f < 3) checkStrobesLow();   // Reset bubbles still in Q103H
                else checkQ103();
                if (f < TotalFetches) fetchOne(f);
                else pendInst = `NOP_INST;      // Drain
                f++;
            end
        end
        reportTest(lastTest);
        $display("Summary: 6 tests, %0d checks, %0d errors", checkCnt, errCnt);
        if (errCnt == 0 && !timedOut) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+hdl
hdl/core4tPkg.sv
hdl/threadFetch.sv
hdl/instDecode.sv
hdl/threadRegFile.sv
hdl/executeStage.sv
hdl/memWriteback.sv
hdl/core4t.sv
dv/tbClockGen.sv
dv/core4tTb.sv
